/* hdl/fifo_demo_pkg.sv */
// assumes fifo_depth is a power of two equal to the digit count and segments are active high
package fifo_demo_pkg;

    //----------------------------------------------------------------------
    // fifo geometry

    localparam int fifo_width = 4;
    localparam int fifo_depth = 8;
    localparam int ptr_w      = $clog2 (fifo_depth);
    localparam int w_digit    = fifo_depth;
    localparam int w_led      = 8;

    typedef logic [fifo_width - 1:0] nibble_t;
    typedef logic [ptr_w      - 1:0] ptr_t;
    // one extra bit so that a full fifo can be counted
    typedef logic [ptr_w         :0] cnt_t;
    typedef logic [             7:0] seg_t;
    typedef logic [w_digit    - 1:0] digit_t;

    //----------------------------------------------------------------------
    // write data, scrambled so consecutive pushes are easy to tell apart

    localparam nibble_t pattern_table [0:15] = '{
        4'h2, 4'h6, 4'hd, 4'hb, 4'h7, 4'he, 4'hc, 4'h4,
        4'h1, 4'h0, 4'h9, 4'ha, 4'hf, 4'h5, 4'h8, 4'h3 };

    //----------------------------------------------------------------------
    // segment words, a is bit 7 and the dot h is bit 0

    localparam seg_t seg_dash = 8'b0000_0010;
    localparam seg_t seg_dot  = 8'b0000_0001;

    localparam seg_t hex_seg [0:15] = '{
        8'b1111_1100, 8'b0110_0000, 8'b1101_1010, 8'b1111_0010,
        8'b0110_0110, 8'b1011_0110, 8'b1011_1110, 8'b1110_0000,
        8'b1111_1110, 8'b1111_0110, 8'b1110_1110, 8'b0011_1110,
        8'b1001_1100, 8'b0111_1010, 8'b1001_1110, 8'b1000_1110 };

    //----------------------------------------------------------------------
    // timing, in clk cycles

    // one operation per second with a 50 MHz board clock
    localparam int tick_period_default = 50_000_000;
    localparam int scan_period         = 16;
    localparam int scan_w              = $clog2 (scan_period);

endpackage

/* hdl/tick_gen.sv */
// single clk domain only; tick_period must be 2 or more
`timescale 1ns/100ps

module tick_gen
    import fifo_demo_pkg::*;
#(
    parameter int tick_period = tick_period_default
)
(
    input        clk,
    input        rst_n,
    output logic tick
);

    // counter only needs to hold tick_period - 1
    localparam int cnt_w = $clog2 (tick_period);

    logic [cnt_w - 1:0] cnt;

    //----------------------------------------------------------------------
    // down-counter, reloads on zero and fires tick for one cycle

    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            cnt  <= cnt_w' (tick_period - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= cnt_w' (tick_period - 1);
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end

endmodule

/* hdl/pattern_source.sv */
// push must already be gated by full; the sequence repeats every sixteen pushes
`timescale 1ns/100ps

module pattern_source
    import fifo_demo_pkg::*;
(
    input           clk,
    input           rst_n,
    input           push,
    output nibble_t write_data
);

    // one table entry per nibble value, so the index is nibble wide
    nibble_t index;

    //----------------------------------------------------------------------
    // push counter

    // advances in the cycle after each push
    // wraps naturally after the last table entry
    always_ff @ (posedge clk)
        if (~ rst_n)
            index <= '0;
        else if (push)
            index <= index + 1'b1;

    //----------------------------------------------------------------------
    // table lookup

    // combinational from the index, so the data is ready
    // before the push strobe that consumes it
    assign write_data = pattern_table [index];

endmodule

/* hdl/debug_fifo.sv */
// no push into a full fifo and no pop from an empty one, even together with the other strobe
`timescale 1ns/100ps

module debug_fifo
    import fifo_demo_pkg::*;
(
    input                              clk,
    input                              rst_n,
    input                              push,
    input                              pop,
    input  nibble_t                    write_data,

    output nibble_t                    read_data,
    output logic                       empty,
    output logic                       full,
    output cnt_t                       count,

    output logic    [fifo_depth - 1:0] debug_valid,
    output nibble_t [fifo_depth - 1:0] debug_data,
    output ptr_t                       wr_ptr,
    output ptr_t                       rd_ptr
);

    nibble_t [fifo_depth - 1:0] slot_data;
    logic    [fifo_depth - 1:0] slot_valid;
    logic    [fifo_depth - 1:0] valid_next;
    cnt_t                       count_next;

    //----------------------------------------------------------------------
    // storage

    // slot contents only matter while the slot is valid
    always_ff @ (posedge clk)
        if (push)
            slot_data [wr_ptr] <= write_data;

    // pop clears first, push sets second
    // both at once never hit the same slot since
    // the pointers only meet when empty or full
    always_comb
    begin
        valid_next = slot_valid;

        if (pop)
            valid_next [rd_ptr] = 1'b0;

        if (push)
            valid_next [wr_ptr] = 1'b1;
    end

    //----------------------------------------------------------------------
    // pointers, occupancy and flags

    assign count_next = count + cnt_t' (push) - cnt_t' (pop);

    // pointers are log2 of a power-of-two depth, so they wrap by themselves
    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            empty      <= 1'b1;
            full       <= 1'b0;
            slot_valid <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;

            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            count      <= count_next;
            // flags come from next-state count so they line up with count
            empty      <= count_next == '0;
            full       <= count_next == cnt_t' (fifo_depth);
            slot_valid <= valid_next;
        end

    //----------------------------------------------------------------------
    // outputs

    assign read_data   = slot_data [rd_ptr];
    assign debug_valid = slot_valid;
    assign debug_data  = slot_data;

    //----------------------------------------------------------------------
    // checks

    // gating lives in the top, these catch a missing guard there
    no_push_when_full : assert property (
        @ (posedge clk) disable iff (~ rst_n) !(push && full));

    no_pop_when_empty : assert property (
        @ (posedge clk) disable iff (~ rst_n) !(pop && empty));

    count_in_range : assert property (
        @ (posedge clk) disable iff (~ rst_n) count <= cnt_t' (fifo_depth));

endmodule

/* hdl/fifo_display.sv */
// segments and digit selects are active high; slot 0 is shown on the leftmost digit
`timescale 1ns/100ps

module fifo_display
    import fifo_demo_pkg::*;
(
    input                              clk,
    input                              rst_n,

    input  logic    [fifo_depth - 1:0] debug_valid,
    input  nibble_t [fifo_depth - 1:0] debug_data,
    input  ptr_t                       wr_ptr,
    input  ptr_t                       rd_ptr,

    output seg_t                       abcdefgh,
    output digit_t                     digit
);

    logic [scan_w - 1:0] scan_cnt;
    logic                scan_step;
    digit_t              digit_next;
    ptr_t                slot;
    seg_t                seg_next;

    //----------------------------------------------------------------------
    // scan timing

    // each digit stays lit for scan_period cycles
    assign scan_step = scan_cnt == scan_w' (scan_period - 1);

    always_ff @ (posedge clk)
        if (~ rst_n)
            scan_cnt <= '0;
        else if (scan_step)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;

    // rotate right, the rightmost digit wraps back to the leftmost
    assign digit_next = scan_step ? { digit [0], digit [w_digit - 1:1] } : digit;

    //----------------------------------------------------------------------
    // slot selection

    // digit bit i shows slot fifo_depth - 1 - i
    // looked up from the next digit so segments and select stay paired
    always_comb
    begin
        slot = '0;

        for (int i = 0; i < w_digit; i++)
            if (digit_next [i])
                slot = ptr_t' (fifo_depth - 1 - i);
    end

    //----------------------------------------------------------------------
    // segment word

    always_comb
    begin
        if (debug_valid [slot])
            seg_next = hex_seg [debug_data [slot]];
        else
            seg_next = seg_dash;

        // dot marks where the pointers sit
        if (slot == wr_ptr || slot == rd_ptr)
            seg_next = seg_next | seg_dot;
    end

    //----------------------------------------------------------------------
    // output registers

    // reset value matches an empty fifo with both pointers on slot 0
    always_ff @ (posedge clk)
        if (~ rst_n)
        begin
            digit    <= { 1'b1, { (w_digit - 1) { 1'b0 } } };
            abcdefgh <= seg_dash | seg_dot;
        end
        else
        begin
            digit    <= digit_next;
            abcdefgh <= seg_next;
        end

    //----------------------------------------------------------------------
    // checks

    // exactly one digit lit at any time, across the whole rotation
    digit_one_hot : assert property (
        @ (posedge clk) disable iff (~ rst_n) $onehot (digit));

endmodule

/* hdl/fifo_demo_top.sv */
// keys are taken as already synchronous to clk and are sampled only on a tick
`timescale 1ns/100ps

module fifo_demo_top
    import fifo_demo_pkg::*;
#(
    parameter int tick_period = tick_period_default
)
(
    input                        clk,
    input                        rst_n,
    input        [          1:0] key,
    output logic [w_led   - 1:0] led,
    output seg_t                 abcdefgh,
    output digit_t               digit
);

    logic                       tick;
    logic                       push;
    logic                       pop;
    logic                       empty;
    logic                       full;
    nibble_t                    write_data;
    cnt_t                       count;
    logic    [fifo_depth - 1:0] debug_valid;
    nibble_t [fifo_depth - 1:0] debug_data;
    ptr_t                       wr_ptr;
    ptr_t                       rd_ptr;

    //----------------------------------------------------------------------
    // operation strobes

    tick_gen #(.tick_period (tick_period)) u_tick_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    // key[1] pushes, key[0] pops, never against the flags
    assign push = tick & key [1] & ~ full;
    assign pop  = tick & key [0] & ~ empty;

    //----------------------------------------------------------------------
    // datapath

    pattern_source u_pattern_source (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .write_data (write_data)
    );

    // read data has no consumer on the board
    debug_fifo u_debug_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .pop         (pop),
        .write_data  (write_data),
        .read_data   (),
        .empty       (empty),
        .full        (full),
        .count       (count),
        .debug_valid (debug_valid),
        .debug_data  (debug_data),
        .wr_ptr      (wr_ptr),
        .rd_ptr      (rd_ptr)
    );

    fifo_display u_fifo_display (
        .clk         (clk),
        .rst_n       (rst_n),
        .debug_valid (debug_valid),
        .debug_data  (debug_data),
        .wr_ptr      (wr_ptr),
        .rd_ptr      (rd_ptr),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

    //----------------------------------------------------------------------
    // status leds

    // count on the upper nibble, bits 3 and 2 unused
    assign led = { count, 2'b00, full, empty };

endmodule

/* dv/fifo_demo_tb.sv */
// runs with tick_period 4 and a fixed LFSR seed; stops at the first mismatch
`timescale 1ns/100ps

module fifo_demo_tb
    import fifo_demo_pkg::*;
();

    localparam int tick_period    = 4;
    localparam int reset_cycles   = 16;
    localparam int run_cycles     = 4000;
    // run length plus a 10 percent margin
    localparam int timeout_cycles = (run_cycles + reset_cycles) * 11 / 10;
    // cycles per key burst, long enough to fill or drain from any state
    localparam int burst_cycles   = 48;
    localparam logic [31:0] seed  = 32'h5f0f_4b78;

    logic               clk;
    logic               rst_n;
    logic [1:0]         key;
    logic [w_led - 1:0] led;
    seg_t               abcdefgh;
    digit_t             digit;

    logic [31:0]        lfsr_state;
    int                 cycle_count = 0;

    // model state, as it stands after each clock edge
    logic                m_reset_seen = 1'b0;
    int                  m_cycles;
    logic                m_tick;
    logic                m_push;
    logic                m_pop;
    nibble_t             m_index;
    nibble_t             m_data [fifo_depth];
    logic [fifo_depth - 1:0] m_valid;
    ptr_t                m_wr;
    ptr_t                m_rd;
    cnt_t                m_count;
    logic                m_empty;
    logic                m_full;
    int                  m_scan;
    digit_t              m_digit;

    // fifo state one cycle back, which is what the display shows
    nibble_t             d_data [fifo_depth];
    logic [fifo_depth - 1:0] d_valid;
    ptr_t                d_wr;
    ptr_t                d_rd;

    // proof that the stimulus reached the corner cases
    logic                saw_full  = 1'b0;
    logic                saw_drain = 1'b0;
    logic                saw_both  = 1'b0;

    fifo_demo_top #(.tick_period (tick_period)) u_fifo_demo_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~ clk;
    end

    //----------------------------------------------------------------------
    // random bits and failure handling

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic draw_bit ();
        if (lfsr_state [0])
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
        else
            lfsr_state = lfsr_state >> 1;
        return lfsr_state [0];
    endfunction

    task automatic abort_run ();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_seg (input seg_t actual, input seg_t expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: abcdefgh expected %b actual %b",
                $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_digit (input digit_t actual, input digit_t expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: digit expected %b actual %b",
                $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_led (input logic [w_led - 1:0] actual,
                              input logic [w_led - 1:0] expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: led expected %b actual %b",
                $time, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_count (input cnt_t actual, input cnt_t expected);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: count expected %0d actual %0d",
                $time, expected, actual);
            abort_run();
        end
    endtask

    //----------------------------------------------------------------------
    // reference model

    // lit digit bit i shows slot fifo_depth - 1 - i
    function automatic seg_t expected_segments ();
        ptr_t slot;
        seg_t word;
        slot = '0;
        for (int i = 0; i < w_digit; i++)
            if (m_digit [i])
                slot = ptr_t' (fifo_depth - 1 - i);
        word = d_valid [slot] ? hex_seg [d_data [slot]] : seg_dash;
        // dot h is bit 0
        if (slot == d_wr || slot == d_rd)
            word = word | 8'b0000_0001;
        return word;
    endfunction

    always @ (posedge clk)
    begin
        if (! rst_n)
        begin
            m_reset_seen = 1'b1;
            m_cycles     = 0;
            m_tick       = 1'b0;
            m_index      = '0;
            m_valid      = '0;
            m_wr         = '0;
            m_rd         = '0;
            m_count      = '0;
            m_empty      = 1'b1;
            m_full       = 1'b0;
            d_valid      = '0;
            d_wr         = '0;
            d_rd         = '0;
            m_scan       = 0;
            m_digit      = digit_t' (1) << (w_digit - 1);
        end
        else
        begin
            d_valid = m_valid;
            d_data  = m_data;
            d_wr    = m_wr;
            d_rd    = m_rd;

            // keys only act on a tick and never against the flags
            m_push = m_tick && key [1] && ! m_full;
            m_pop  = m_tick && key [0] && ! m_empty;

            // a key held against a flag on a tick exercises the gating
            if (m_tick && key [1] && m_full)
                saw_full = 1'b1;
            if (m_tick && key [0] && m_empty)
                saw_drain = 1'b1;

            if (m_push)
            begin
                m_data [m_wr]  = pattern_table [m_index];
                m_valid [m_wr] = 1'b1;
                m_wr           = m_wr + 1'b1;
                m_index        = m_index + 1'b1;
            end
            if (m_pop)
            begin
                m_valid [m_rd] = 1'b0;
                m_rd           = m_rd + 1'b1;
            end

            m_count = m_count + cnt_t' (m_push) - cnt_t' (m_pop);
            m_empty = m_count == '0;
            m_full  = m_count == cnt_t' (fifo_depth);

            if (m_push && m_pop)
                saw_both = 1'b1;

            // tick rises every tick_period cycles after reset release
            m_cycles++;
            m_tick = (m_cycles % tick_period) == 0;

            // scan moves one digit right and wraps to the leftmost
            if (m_scan == scan_period - 1)
            begin
                m_scan  = 0;
                m_digit = { m_digit [0], m_digit [w_digit - 1:1] };
            end
            else
                m_scan++;
        end
    end

    // outputs settle after the rising edge, so compare on the falling one
    always @ (negedge clk)
        if (m_reset_seen)
        begin
            // occupancy field first, then the whole led word with the flags
            check_count (cnt_t' (led [7:4]), m_count);
            check_led   (led, { m_count, 2'b00, m_full, m_empty });
            check_digit (digit, m_digit);
            check_seg   (abcdefgh, expected_segments ());
        end

    //----------------------------------------------------------------------
    // timeout

    always @ (posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles)
        begin
            $display("timeout: the run did not end within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    //----------------------------------------------------------------------
    // stimulus

    initial
    begin
        logic biased;
        logic direction;
        logic k1;
        logic k0;

        biased     = 1'b0;
        direction  = 1'b0;
        rst_n      = 1'b0;
        key        = 2'b00;
        lfsr_state = seed;

        repeat (reset_cycles) @ (posedge clk);
        rst_n <= 1'b1;

        for (int n = 0; n < run_cycles; n++)
        begin
            @ (posedge clk);
            // a biased burst holds one key so the fifo fills or drains
            if (n % burst_cycles == 0)
            begin
                biased    = draw_bit();
                direction = draw_bit();
            end
            if (biased)
                key <= direction ? 2'b10 : 2'b01;
            else
            begin
                k1 = draw_bit();
                k0 = draw_bit();
                key <= { k1, k0 };
            end
        end

        if (! saw_full || ! saw_drain || ! saw_both)
        begin
            $display("stimulus never pushed when full, popped when empty, or did both at once");
            abort_run();
        end
        else
        begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* sources.f */
hdl/fifo_demo_pkg.sv
hdl/tick_gen.sv
hdl/pattern_source.sv
hdl/debug_fifo.sv
hdl/fifo_display.sv
hdl/fifo_demo_top.sv
dv/fifo_demo_tb.sv

/* Makefile */
# Verilator build for the FIFO demo; override any variable on the command line

TOP             ?= fifo_demo_tb
RTL_TOP         ?= fifo_demo_top
FILELIST        ?= sources.f
BUILD_DIR       ?= obj_dir
SEED_LOG        ?= sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --assert --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VERILATOR_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(SEED_LOG)
	@if grep -q "Result: FAILED" $(SEED_LOG); then \
		echo "simulation failed, see $(SEED_LOG)"; exit 1; \
	elif ! grep -q "Result: PASSED" $(SEED_LOG); then \
		echo "simulation ended without a result, see $(SEED_LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(SEED_LOG)
